// ==== src/rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Machine word width for RV64I
`define XLEN 64

// Architectural integer registers, x0 included
`define NUM_REGS 32

// Bits needed to name one register
`define REG_ADDR_W 5

`endif

// ==== src/isaPkg.sv ====
`include "rv_config.svh"

package isaPkg;

    typedef logic [`XLEN-1:0] xword_t;
    typedef logic [`REG_ADDR_W-1:0] regAddr_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        SYSTEM = 7'b1110011
    } opcode_e;

    // One fetched word seen as R-type or as I-type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            regAddr_t   rs2;
            regAddr_t   rs1;
            logic [2:0] funct3;
            regAddr_t   rd;
            opcode_e    opcode;
        } rForm;
        struct packed {
            logic [11:0] imm12;
            regAddr_t    rs1;
            logic [2:0]  funct3;
            regAddr_t    rd;
            opcode_e     opcode;
        } iForm;
    } instrWord_u;

endpackage

// ==== src/pipePkg.sv ====
`include "rv_config.svh"

package pipePkg;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        PASSB
    } aluOp_e;

    // Operand sources that decode resolves
    typedef enum logic [1:0] {RS1, PC, ZERO} srcASel_e;
    typedef enum logic [1:0] {RS2, IMM, FOUR} srcBSel_e;

    // Values follow the mcause encoding
    typedef enum logic [3:0] {
        NONE                = 4'd0,
        ILLEGAL_INSTRUCTION = 4'd2,
        ECALL_U             = 4'd8
    } excCode_e;

endpackage

// ==== src/mainDecoder.sv ====
`timescale 1ns/100ps

module mainDecoder import isaPkg::*, pipePkg::*; (
    input  instrWord_u instr,
    output xword_t     imm,
    output regAddr_t   rs1,
    output regAddr_t   rs2,
    output regAddr_t   rd,
    output aluOp_e     aluOp,
    output srcASel_e   srcA,
    output srcBSel_e   srcB,
    output logic       isWriteBack,
    output logic       isBranch,
    output logic       isJump,
    output logic       branchNe,
    output logic       isEcall,
    output logic       illegal
);

    xword_t immI;
    xword_t immU;
    xword_t immJ;
    xword_t immB;

    assign rs1 = instr.rForm.rs1;
    assign rs2 = instr.rForm.rs2;
    assign rd  = instr.rForm.rd;

    // Immediates are sign extended by the signed size casts
    assign immI = xword_t'($signed(instr.iForm.imm12));
    assign immU = xword_t'($signed({instr.iForm.imm12, instr.iForm.rs1,
                                    instr.iForm.funct3, 12'b0}));
    assign immJ = xword_t'($signed({instr.iForm.imm12[11], instr.iForm.rs1,
                                    instr.iForm.funct3, instr.iForm.imm12[0],
                                    instr.iForm.imm12[10:1], 1'b0}));
    // B-type bits sit in the funct7 and rd slots
    assign immB = xword_t'($signed({instr.rForm.funct7[6], instr.rForm.rd[0],
                                    instr.rForm.funct7[5:0], instr.rForm.rd[4:1], 1'b0}));

    always_comb begin
        imm         = immI;
        aluOp       = ADD;
        srcA        = RS1;
        srcB        = RS2;
        isWriteBack = 1'b0;
        isBranch    = 1'b0;
        isJump      = 1'b0;
        branchNe    = 1'b0;
        isEcall     = 1'b0;
        illegal     = 1'b0;

        case (instr.rForm.opcode)
            OP: begin
                isWriteBack = 1'b1;
                case ({instr.rForm.funct7, instr.rForm.funct3})
                    {7'b0000000, 3'b000}: aluOp = ADD;
                    {7'b0100000, 3'b000}: aluOp = SUB;
                    {7'b0000000, 3'b111}: aluOp = AND;
                    {7'b0000000, 3'b110}: aluOp = OR;
                    {7'b0000000, 3'b100}: aluOp = XOR;
                    {7'b0000000, 3'b010}: aluOp = SLT;
                    default: illegal = 1'b1;
                endcase
            end
            OP_IMM: begin
                isWriteBack = 1'b1;
                srcB        = IMM;
                case (instr.iForm.funct3)
                    3'b000: aluOp = ADD;
                    3'b111: aluOp = AND;
                    3'b110: aluOp = OR;
                    3'b100: aluOp = XOR;
                    default: illegal = 1'b1;
                endcase
            end
            LUI: begin
                isWriteBack = 1'b1;
                imm         = immU;
                srcA        = ZERO;
                srcB        = IMM;
                aluOp       = PASSB;
            end
            // Link value pc + 4 comes out of the ALU
            JAL: begin
                isWriteBack = 1'b1;
                isJump      = 1'b1;
                imm         = immJ;
                srcA        = PC;
                srcB        = FOUR;
            end
            JALR: begin
                if (instr.iForm.funct3 == 3'b000) begin
                    isWriteBack = 1'b1;
                    isJump      = 1'b1;
                    srcA        = PC;
                    srcB        = FOUR;
                end else begin
                    illegal = 1'b1;
                end
            end
            BRANCH: begin
                imm = immB;
                case (instr.rForm.funct3)
                    3'b000: isBranch = 1'b1;
                    3'b001: begin
                        isBranch = 1'b1;
                        branchNe = 1'b1;
                    end
                    default: illegal = 1'b1;
                endcase
            end
            SYSTEM: begin
                if (instr.iForm.imm12 == '0 && instr.iForm.rs1 == '0 &&
                    instr.iForm.funct3 == '0 && instr.iForm.rd == '0) begin
                    isEcall = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            default: illegal = 1'b1;
        endcase

        if (illegal) begin
            isWriteBack = 1'b0;
        end
    end

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/100ps
`include "rv_config.svh"

module regFile import isaPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  regAddr_t rs1Addr,
    input  regAddr_t rs2Addr,
    output xword_t   rs1Data,
    output xword_t   rs2Data,
    input  logic     we,
    input  regAddr_t wAddr,
    input  xword_t   wData
);

    xword_t regs [`NUM_REGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wAddr != '0) begin
            regs[wAddr] <= wData;
        end
    end

    // x0 is hardwired to zero
    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

// ==== src/decodeStage.sv ====
`timescale 1ns/100ps

module decodeStage import isaPkg::*, pipePkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       inValid,
    input  instrWord_u instr,
    input  xword_t     pc,
    input  logic       advance,
    input  logic       flush,
    input  logic       predictTaken,
    output regAddr_t   rs1Addr,
    output regAddr_t   rs2Addr,
    input  xword_t     rs1Data,
    input  xword_t     rs2Data,
    input  logic       fwd1Valid,
    input  logic       fwd1Wb,
    input  regAddr_t   fwd1Rd,
    input  xword_t     fwd1Data,
    input  logic       fwd2Valid,
    input  logic       fwd2Wb,
    input  regAddr_t   fwd2Rd,
    input  xword_t     fwd2Data,
    output logic       redirectValid,
    output xword_t     redirectTarget,
    output xword_t     predictPc,
    output logic       idValid,
    output xword_t     idPc,
    output xword_t     idPcPlus4,
    output xword_t     idOpA,
    output xword_t     idOpB,
    output aluOp_e     idAluOp,
    output regAddr_t   idRd,
    output logic       idWb,
    output logic       idExcValid,
    output excCode_e   idExcCode
);

    xword_t   imm;
    regAddr_t rd;
    aluOp_e   aluOp;
    srcASel_e srcA;
    srcBSel_e srcB;
    logic     isWriteBack;
    logic     isBranch;
    logic     isJump;
    logic     isEcall;
    logic     illegal;
    xword_t   opRs1;
    xword_t   opRs2;
    xword_t   opA;
    xword_t   opB;
    logic     excValid;
    excCode_e excCode;

    // A forward source hits when it writes the register being read and that is not x0
    function automatic logic srcHit(input logic v, input logic wb, input regAddr_t dst,
                                    input regAddr_t src);
        return v && wb && (dst == src) && (src != '0);
    endfunction

    mainDecoder decoder (
        .instr      (instr),
        .imm        (imm),
        .rs1        (rs1Addr),
        .rs2        (rs2Addr),
        .rd         (rd),
        .aluOp      (aluOp),
        .srcA       (srcA),
        .srcB       (srcB),
        .isWriteBack(isWriteBack),
        .isBranch   (isBranch),
        .isJump     (isJump),
        .branchNe   (),
        .isEcall    (isEcall),
        .illegal    (illegal)
    );

    // Stage 1 is newer than stage 2 and both are newer than the register file
    assign opRs1 = srcHit(fwd1Valid, fwd1Wb, fwd1Rd, rs1Addr) ? fwd1Data :
                   srcHit(fwd2Valid, fwd2Wb, fwd2Rd, rs1Addr) ? fwd2Data : rs1Data;
    assign opRs2 = srcHit(fwd1Valid, fwd1Wb, fwd1Rd, rs2Addr) ? fwd1Data :
                   srcHit(fwd2Valid, fwd2Wb, fwd2Rd, rs2Addr) ? fwd2Data : rs2Data;

    assign predictPc      = pc;
    assign redirectTarget = ((instr.iForm.opcode == JALR) ? opRs1 : pc) + imm;
    assign redirectValid  = inValid && (isJump || (isBranch && predictTaken));

    always_comb begin
        case (srcA)
            PC:      opA = pc;
            ZERO:    opA = '0;
            default: opA = opRs1;
        endcase
        case (srcB)
            IMM:     opB = imm;
            FOUR:    opB = xword_t'(4);
            default: opB = opRs2;
        endcase
    end

    // Illegal wins over ecall
    always_comb begin
        excValid = 1'b0;
        excCode  = NONE;
        if (inValid && !flush) begin
            if (illegal) begin
                excValid = 1'b1;
                excCode  = ILLEGAL_INSTRUCTION;
            end else if (isEcall) begin
                excValid = 1'b1;
                excCode  = ECALL_U;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idValid    <= 1'b0;
            idWb       <= 1'b0;
            idExcValid <= 1'b0;
        end else if (advance) begin
            idValid    <= inValid && !flush;
            idWb       <= inValid && !flush && isWriteBack && !excValid;
            idExcValid <= excValid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            idPc      <= pc;
            idPcPlus4 <= pc + xword_t'(4);
            idOpA     <= opA;
            idOpB     <= opB;
            idAluOp   <= aluOp;
            idRd      <= rd;
            idExcCode <= excCode;
        end
    end

endmodule

// ==== src/executeStage.sv ====
`timescale 1ns/100ps

module executeStage import isaPkg::*, pipePkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     advance,
    input  logic     idValid,
    input  xword_t   idPc,
    input  xword_t   idOpA,
    input  xword_t   idOpB,
    input  aluOp_e   idAluOp,
    input  regAddr_t idRd,
    input  logic     idWb,
    input  logic     idExcValid,
    input  excCode_e idExcCode,
    output logic     fwd1Valid,
    output logic     fwd1Wb,
    output regAddr_t fwd1Rd,
    output xword_t   fwd1Data,
    output logic     fwd2Valid,
    output logic     fwd2Wb,
    output regAddr_t fwd2Rd,
    output xword_t   fwd2Data,
    output logic     retireValid,
    output logic     retireWb,
    output regAddr_t retireRd,
    output xword_t   retireData,
    output xword_t   retirePc,
    output logic     excValid,
    output excCode_e excCode,
    output xword_t   excPc
);

    xword_t   aluResult;
    logic     exValid;
    logic     exWb;
    logic     exExcValid;
    regAddr_t exRd;
    xword_t   exData;
    xword_t   exPc;
    excCode_e exExcCode;

    always_comb begin
        case (idAluOp)
            SUB:     aluResult = idOpA - idOpB;
            AND:     aluResult = idOpA & idOpB;
            OR:      aluResult = idOpA | idOpB;
            XOR:     aluResult = idOpA ^ idOpB;
            SLT:     aluResult = xword_t'($signed(idOpA) < $signed(idOpB));
            PASSB:   aluResult = idOpB;
            default: aluResult = idOpA + idOpB;
        endcase
    end

    // Stage-1 forward source straight off the ALU
    assign fwd1Valid = idValid;
    assign fwd1Wb    = idWb;
    assign fwd1Rd    = idRd;
    assign fwd1Data  = aluResult;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exValid    <= 1'b0;
            exWb       <= 1'b0;
            exExcValid <= 1'b0;
        end else if (advance) begin
            exValid    <= idValid;
            exWb       <= idValid && idWb && (idRd != '0) && !idExcValid;
            exExcValid <= idValid && idExcValid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            exRd      <= idRd;
            exData    <= aluResult;
            exPc      <= idPc;
            exExcCode <= idExcCode;
        end
    end

    assign fwd2Valid   = exValid;
    assign fwd2Wb      = exWb;
    assign fwd2Rd      = exRd;
    assign fwd2Data    = exData;

    assign retireValid = exValid;
    assign retireWb    = exWb;
    assign retireRd    = exRd;
    assign retireData  = exData;
    assign retirePc    = exPc;
    assign excValid    = exExcValid;
    assign excCode     = exExcCode;
    assign excPc       = exPc;

endmodule

// ==== src/decodeCore.sv ====
`timescale 1ns/100ps

module decodeCore import isaPkg::*, pipePkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       inValid,
    input  instrWord_u instr,
    input  xword_t     pc,
    input  logic       advance,
    input  logic       flush,
    input  logic       predictTaken,
    output logic       redirectValid,
    output xword_t     redirectTarget,
    output xword_t     predictPc,
    output logic       retireValid,
    output logic       retireWb,
    output regAddr_t   retireRd,
    output xword_t     retireData,
    output xword_t     retirePc,
    output logic       excValid,
    output excCode_e   excCode,
    output xword_t     excPc
);

    regAddr_t rs1Addr;
    regAddr_t rs2Addr;
    xword_t   rs1Data;
    xword_t   rs2Data;
    logic     fwd1Valid;
    logic     fwd1Wb;
    regAddr_t fwd1Rd;
    xword_t   fwd1Data;
    logic     fwd2Valid;
    logic     fwd2Wb;
    regAddr_t fwd2Rd;
    xword_t   fwd2Data;
    logic     idValid;
    xword_t   idPc;
    xword_t   idOpA;
    xword_t   idOpB;
    aluOp_e   idAluOp;
    regAddr_t idRd;
    logic     idWb;
    logic     idExcValid;
    excCode_e idExcCode;
    logic     regWe;

    // Write back from EX/WB freezes with the rest of the pipe
    assign regWe = fwd2Valid && fwd2Wb && advance;

    decodeStage decode (.idPcPlus4(), .*);

    executeStage execute (.*);

    regFile regs (.we(regWe), .wAddr(fwd2Rd), .wData(fwd2Data), .*);

endmodule

// ==== bench/decodeCore_props.sv ====
`timescale 1ns/100ps

module decodeCore_props (
    input logic clk,
    input logic rst,
    input logic inValid,
    input logic redirectValid,
    input logic retireValid,
    input logic retireWb,
    input logic excValid
);

    int unsigned failures = 0;

    property quietInReset;
        @(posedge clk) rst |-> !retireValid;
    endproperty

    // A trapping instruction never writes a register
    property excBlocksWrite;
        @(posedge clk) disable iff (rst) excValid |-> !retireWb;
    endproperty

    property redirectNeedsValid;
        @(posedge clk) disable iff (rst) redirectValid |-> inValid;
    endproperty

    quietInResetCheck: assert property (quietInReset) else begin
        failures++;
        $error("retireValid high while reset is asserted");
    end

    excBlocksWriteCheck: assert property (excBlocksWrite) else begin
        failures++;
        $error("retireWb high together with excValid");
    end

    redirectNeedsValidCheck: assert property (redirectNeedsValid) else begin
        failures++;
        $error("redirectValid high without inValid");
    end

endmodule

bind decodeCore decodeCore_props props (.*);

// ==== bench/decodeCore_tb.sv ====
`timescale 1ns/100ps

module decodeCore_tb;

    localparam int DrainLimit = 40;
    localparam int MaxLines = 500;

    logic        clk;
    logic        rst;
    logic        inValid;
    logic [31:0] instr;
    logic [63:0] pc;
    logic        advance;
    logic        flush;
    logic        predictTaken;
    logic        redirectValid;
    logic [63:0] redirectTarget;
    logic [63:0] predictPc;
    logic        retireValid;
    logic        retireWb;
    logic [4:0]  retireRd;
    logic [63:0] retireData;
    logic [63:0] retirePc;
    logic        excValid;
    logic [3:0]  excCode;
    logic [63:0] excPc;

    // Expected retirements with the oldest first
    logic        wbQ [$];
    logic [4:0]  rdQ [$];
    logic [63:0] dataQ [$];
    logic        excQ [$];
    logic [3:0]  codeQ [$];
    logic [63:0] pcQ [$];

    int mismatches;
    int otherErrors;

    decodeCore uut (
        .clk           (clk),
        .rst           (rst),
        .inValid       (inValid),
        .instr         (instr),
        .pc            (pc),
        .advance       (advance),
        .flush         (flush),
        .predictTaken  (predictTaken),
        .redirectValid (redirectValid),
        .redirectTarget(redirectTarget),
        .predictPc     (predictPc),
        .retireValid   (retireValid),
        .retireWb      (retireWb),
        .retireRd      (retireRd),
        .retireData    (retireData),
        .retirePc      (retirePc),
        .excValid      (excValid),
        .excCode       (excCode),
        .excPc         (excPc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic compareValue(input string name, input logic [63:0] expVal,
                                input logic [63:0] gotVal);
        if (gotVal !== expVal) begin
            mismatches++;
            $display("MISMATCH at %0t: %s expected %h got %h", $time, name, expVal, gotVal);
        end
    endtask

    task automatic checkRedirect(input logic expValid, input logic [63:0] expTarget);
        compareValue("redirectValid", expValid, redirectValid);
        if (expValid) begin
            compareValue("redirectTarget", expTarget, redirectTarget);
        end
    endtask

    // EX/WB content retires at the coming edge only if advance is high
    task automatic checkRetire();
        logic        expWb;
        logic [4:0]  expRd;
        logic [63:0] expData;
        logic        expExc;
        logic [3:0]  expCode;
        logic [63:0] expPc;
        if (retireValid && advance) begin
            if (wbQ.size() == 0) begin
                otherErrors++;
                $display("%0t: an instruction retired that was never expected", $time);
            end else begin
                expWb   = wbQ.pop_front();
                expRd   = rdQ.pop_front();
                expData = dataQ.pop_front();
                expExc  = excQ.pop_front();
                expCode = codeQ.pop_front();
                expPc   = pcQ.pop_front();
                compareValue("retireWb", expWb, retireWb);
                compareValue("excValid", expExc, excValid);
                compareValue("retirePc", expPc, retirePc);
                if (expWb) begin
                    compareValue("retireRd", expRd, retireRd);
                    compareValue("retireData", expData, retireData);
                end
                if (expExc) begin
                    compareValue("excCode", expCode, excCode);
                    compareValue("excPc", expPc, excPc);
                end
            end
        end
    endtask

    task automatic idleCycle();
        @(negedge clk);
        inValid      = 1'b0;
        instr        = '0;
        pc           = '0;
        advance      = 1'b1;
        flush        = 1'b0;
        predictTaken = 1'b0;
        #2;
        compareValue("predictPc", '0, predictPc);
        checkRedirect(1'b0, '0);
        checkRetire();
    endtask

    initial begin
        int          fd;
        int          n;
        int          lineCount;
        int          waited;
        string       lineStr;
        logic        sValid;
        logic [31:0] sInstr;
        logic [63:0] sPc;
        logic        sAdvance;
        logic        sFlush;
        logic        sPredict;
        logic        eRedir;
        logic [63:0] eTarget;
        logic        eRet;
        logic        eWb;
        logic [4:0]  eRd;
        logic [63:0] eData;
        logic        eExc;
        logic [3:0]  eCode;

        mismatches   = 0;
        otherErrors  = 0;
        rst          = 1'b0;
        inValid      = 1'b0;
        instr        = '0;
        pc           = '0;
        advance      = 1'b0;
        flush        = 1'b0;
        predictTaken = 1'b0;
        #1 rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen("bench/decodeCore_stim.txt", "r");
        if (fd == 0) begin
            otherErrors++;
            $display("cannot open the stimulus file bench/decodeCore_stim.txt");
        end else begin
            lineCount = 0;
            while (!$feof(fd) && lineCount < MaxLines) begin
                lineStr = "";
                void'($fgets(lineStr, fd));
                lineCount++;
                if (lineStr.len() > 1 && lineStr.getc(0) != "#") begin
                    n = $sscanf(lineStr, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                sValid, sInstr, sPc, sAdvance, sFlush, sPredict,
                                eRedir, eTarget, eRet, eWb, eRd, eData, eExc, eCode);
                    if (n != 14) begin
                        otherErrors++;
                        $display("stimulus line %0d could not be parsed", lineCount);
                    end else begin
                        @(negedge clk);
                        inValid      = sValid;
                        instr        = sInstr;
                        pc           = sPc;
                        advance      = sAdvance;
                        flush        = sFlush;
                        predictTaken = sPredict;
                        #2;
                        if (eRet) begin
                            wbQ.push_back(eWb);
                            rdQ.push_back(eRd);
                            dataQ.push_back(eData);
                            excQ.push_back(eExc);
                            codeQ.push_back(eCode);
                            pcQ.push_back(sPc);
                        end
                        compareValue("predictPc", sPc, predictPc);
                        checkRedirect(eRedir, eTarget);
                        checkRetire();
                    end
                end
            end
            $fclose(fd);
        end

        waited = 0;
        while (wbQ.size() > 0 && waited < DrainLimit) begin
            idleCycle();
            waited++;
        end
        if (wbQ.size() > 0) begin
            otherErrors++;
            $display("timeout: %0d expected retirements never arrived", wbQ.size());
        end
        // Stray retirements after the drain
        repeat (3) idleCycle();

        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, otherErrors, uut.props.failures);
        if (mismatches == 0 && otherErrors == 0 && uut.props.failures == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+src
src/isaPkg.sv
src/pipePkg.sv
src/mainDecoder.sv
src/regFile.sv
src/decodeStage.sv
src/executeStage.sv
src/decodeCore.sv
bench/decodeCore_props.sv
bench/decodeCore_tb.sv

// ==== Bender.yml ====
package:
  name: decode_core

sources:
  - include_dirs:
      - src
    files:
      - src/isaPkg.sv
      - src/pipePkg.sv
      - src/mainDecoder.sv
      - src/regFile.sv
      - src/decodeStage.sv
      - src/executeStage.sv
      - src/decodeCore.sv
  - target: test
    files:
      - bench/decodeCore_props.sv
      - bench/decodeCore_tb.sv

// ==== bench/decodeCore_stim.txt ====
# valid instr pc advance flush predictTaken | redirValid redirTarget
# | retire wb rd data exc code  (all hex, one line per driven cycle)
1 00500093 1000 1 0 0 0 0 1 1 01 5 0 0
1 ffd00113 1004 1 0 0 0 0 1 1 02 fffffffffffffffd 0 0
1 002081b3 1008 1 0 0 0 0 1 1 03 2 0 0
1 40118233 100c 1 0 0 0 0 1 1 04 fffffffffffffffd 0 0
1 00700293 1010 1 0 0 0 0 1 1 05 7 0 0
1 00900293 1014 1 0 0 0 0 1 1 05 9 0 0
1 00528333 1018 1 0 0 0 0 1 1 06 12 0 0
1 004373b3 101c 1 0 0 0 0 1 1 07 10 0 0
1 0050e433 1020 1 0 0 0 0 1 1 08 d 0 0
1 002444b3 1024 1 0 0 0 0 1 1 09 fffffffffffffff0 0 0
1 00112533 1028 1 0 0 0 0 1 1 0a 1 0 0
1 0ff4f593 102c 1 0 0 0 0 1 1 0b f0 0 0
1 00f5e613 1030 1 0 0 0 0 1 1 0c ff 0 0
1 fff64693 1034 1 0 0 0 0 1 1 0d ffffffffffffff00 0 0
1 12345737 1038 1 0 0 0 0 1 1 0e 12345000 0 0
1 010007ef 103c 1 0 0 1 104c 1 1 0f 1040 0 0
1 00870867 104c 1 0 0 1 12345008 1 1 10 1050 0 0
1 fe208ce3 12345008 1 0 1 1 12345000 1 0 00 0 0 0
1 00209663 12345000 1 0 0 0 0 1 0 00 0 0 0
1 00209663 12345004 1 0 1 1 12345010 1 0 00 0 0 0
1 00000073 12345010 1 0 0 0 0 1 0 00 0 1 8
1 ffffffff 12345014 1 0 0 0 0 1 0 00 0 1 2
1 022081b3 12345018 1 0 0 0 0 1 0 00 0 1 2
1 05500013 1234501c 1 0 0 0 0 1 0 00 0 0 0
1 001008b3 12345020 0 0 0 0 0 0 0 00 0 0 0
1 001008b3 12345020 0 0 0 0 0 0 0 00 0 0 0
1 001008b3 12345020 1 0 0 0 0 1 1 11 5 0 0
1 06300093 12345024 1 1 0 0 0 0 0 00 0 0 0
1 00388933 12345028 1 0 0 0 0 1 1 12 7 0 0
1 000089b3 1234502c 1 0 0 0 0 1 1 13 5 0 0
